/* Bender.yml */
package:
  name: motor_link

sources:
  - files:
      - verilog/driveCmdPkg.sv
      - verilog/byteLink.sv
      - verilog/cmdSelect.sv
      - verilog/jsonFramer.sv
      - verilog/uartSender.sv
      - verilog/motorLinkTop.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/motorLinkTb.sv

/* files.f */
+incdir+testbench
verilog/driveCmdPkg.sv
verilog/byteLink.sv
verilog/cmdSelect.sv
verilog/jsonFramer.sv
verilog/uartSender.sv
verilog/motorLinkTop.sv
testbench/motorLinkTb.sv

/* testbench/motorLinkModel.svh */
`ifndef MOTOR_LINK_MODEL_SVH
`define MOTOR_LINK_MODEL_SVH

// Expected JSON line for one switch code, wheel speeds from the command table
function automatic string expectedText(input driveCmdPkg::driveCmd c);
    string l;
    string r;
    l = "0";                                    // STOP and STOP_ALT
    r = "0";
    case (c)
        driveCmdPkg::LEFT: begin
            l = "-0.00";
            r = "0.12";
        end
        driveCmdPkg::RIGHT: begin
            l = "0.12";
            r = "-0.00";
        end
        driveCmdPkg::FWD_SLOW: begin
            l = "0.05";
            r = "0.05";
        end
        driveCmdPkg::FWD_MED: begin
            l = "0.25";
            r = "0.25";
        end
        driveCmdPkg::FWD_FAST: begin
            l = "0.5";
            r = "0.5";
        end
        driveCmdPkg::REVERSE: begin
            l = "-0.25";
            r = "-0.25";
        end
        default: ;
    endcase
    return {"{\"T\":1,\"L\":", l, ",\"R\":", r, "}\n"};
endfunction

task automatic checkByte(input string what, input driveCmdPkg::msgByte got,
                         input driveCmdPkg::msgByte exp);
    if (got !== exp) begin
        $display("MISMATCH %s got 0x%02h expected 0x%02h", what, got, exp);
        errCount++;
    end
endtask

task automatic checkLen(input string what, input driveCmdPkg::msgLen got,
                        input driveCmdPkg::msgLen exp);
    if (got !== exp) begin
        $display("MISMATCH %s got 0x%02h expected 0x%02h", what, got, exp);
        errCount++;
    end
endtask

`endif

/* testbench/motorLinkTb.sv */
`default_nettype none

module motorLinkTb;

    localparam int BIT_CLKS    = 8;             // Short UART bit for simulation
    localparam int SETTLE      = 16;            // Debounce time in cycles
    localparam int MSG_COUNT   = 12;            // Messages over the whole run
    localparam int MAX_BYTES   = 28;
    localparam int CYCLE_LIMIT = MSG_COUNT * MAX_BYTES * 10 * BIT_CLKS
                               + 40 * 4 * SETTLE + 10000;
    localparam int IDLE_GAP    = 3 * 10 * BIT_CLKS; // Three quiet frames

    logic       clk;
    logic       rst;
    logic [2:0] cmdSel;
    logic       txd;
    logic       busy;
    logic       msgDone;

    int errCount    = 0;
    int testCount   = 0;
    int failedTests = 0;
    int doneCount   = 0;                        // msgDone pulses seen
    int cycleCount  = 0;
    int curLen      = 0;                        // Bytes of the line in progress

    driveCmdPkg::msgByte rxBytes[$];            // Everything received
    int                  msgLens[$];            // One entry per newline
    string               expMsgs[$];            // Lines expected since last clear

    `include "motorLinkModel.svh"

    motorLinkTop #(
        .CLKS_PER_BIT  (BIT_CLKS),
        .FIFO_DEPTH    (4),
        .SETTLE_CYCLES (SETTLE)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .cmdSel  (cmdSel),
        .txd     (txd),
        .busy    (busy),
        .msgDone (msgDone)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles", cycleCount);
            $display("Checks failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (msgDone === 1'b1) begin
            doneCount++;
        end
    end

    // UART receiver that samples each bit near its middle
    initial begin : uartRx
        driveCmdPkg::msgByte b;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && txd === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clk);
                if (txd !== 1'b0) begin
                    $display("Framing error: start bit not low at mid-bit");
                    errCount++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    b[i] = txd;                 // LSB first
                end
                repeat (BIT_CLKS) @(negedge clk);
                if (txd !== 1'b1) begin
                    $display("Framing error: stop bit not high after byte 0x%02h", b);
                    errCount++;
                end
                rxBytes.push_back(b);
                curLen++;
                if (b == 8'h0A) begin
                    msgLens.push_back(curLen);
                    curLen = 0;
                end
            end
        end
    end

    task automatic waitForIdle(input int target);
        while (doneCount < target) @(negedge clk);
        while (busy === 1'b1) @(negedge clk);
        repeat (IDLE_GAP) @(negedge clk); // Catch any unexpected extra line
    endtask

    task automatic holdCode(input driveCmdPkg::driveCmd c);
        cmdSel = 3'(c);
        repeat (SETTLE + 4 + $urandom_range(0, 8)) @(negedge clk);
    endtask

    task automatic compareTraffic(input int doneBase);
        int    pos;
        string exp;
        pos = 0;
        if (msgLens.size() != expMsgs.size()) begin
            $display("Received %0d lines, expected %0d", msgLens.size(), expMsgs.size());
            errCount++;
        end
        if (doneCount - doneBase != expMsgs.size()) begin
            $display("Saw %0d msgDone pulses, expected %0d",
                     doneCount - doneBase, expMsgs.size());
            errCount++;
        end
        foreach (expMsgs[m]) begin
            exp = expMsgs[m];
            if (m < msgLens.size()) begin
                checkLen($sformatf("msgLen[%0d]", m), driveCmdPkg::msgLen'(msgLens[m]),
                         driveCmdPkg::msgLen'(exp.len()));
            end
            for (int i = 0; i < exp.len(); i++) begin
                if (pos < rxBytes.size()) begin
                    checkByte($sformatf("line %0d byte %0d", m, i), rxBytes[pos], exp[i]);
                end else begin
                    $display("Line %0d is missing byte %0d", m, i);
                    errCount++;
                end
                pos++;
            end
        end
        if (rxBytes.size() > pos) begin
            $display("Received %0d bytes more than expected", rxBytes.size() - pos);
            errCount++;
        end
    endtask

    task automatic clearTraffic();
        rxBytes.delete();
        msgLens.delete();
        expMsgs.delete();
        curLen = 0;
    endtask

    task automatic finishTest(input string name, input int errBase);
        testCount++;
        if (errCount == errBase) begin
            $display("PASS %s", name);
        end else begin
            failedTests++;
            $display("FAIL %s (%0d errors)", name, errCount - errBase);
        end
    endtask

    initial begin : mainFlow
        int                   base;
        int                   doneBase;
        int                   badIdle;
        driveCmdPkg::driveCmd code;
        void'($urandom(32'hb3c5));
        clk      = 1'b0;
        rst      = 1'b1;
        cmdSel   = 3'd0;                        // STOP is the first code after reset
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state and the first settled STOP
        base     = errCount;
        doneBase = doneCount;
        @(negedge clk);
        if (txd !== 1'b1) begin
            $display("txd not high after reset");
            errCount++;
        end
        if (busy !== 1'b0) begin
            $display("busy not low after reset");
            errCount++;
        end
        expMsgs.push_back(expectedText(driveCmdPkg::STOP));
        waitForIdle(doneBase + 1);
        compareTraffic(doneBase);
        if (msgLens.size() > 0) begin
            checkLen("firstLen", driveCmdPkg::msgLen'(msgLens[0]), driveCmdPkg::msgLen'(20));
        end
        clearTraffic();
        finishTest("reset and first STOP", base);

        // Every code once with STOP last so each differs from the one before
        for (int c = 1; c <= 8; c++) begin
            code     = driveCmdPkg::driveCmd'(c % 8);
            base     = errCount;
            doneBase = doneCount;
            repeat ($urandom_range(1, 20)) @(negedge clk);
            cmdSel = 3'(code);
            expMsgs.push_back(expectedText(code));
            waitForIdle(doneBase + 1);
            compareTraffic(doneBase);
            clearTraffic();
            finishTest($sformatf("code %0d %s", c % 8, code.name()), base);
        end

        // Glitches away from STOP and back
        base     = errCount;
        doneBase = doneCount;
        for (int g = 0; g < 3; g++) begin
            cmdSel = 3'($urandom_range(1, 7));
            repeat ($urandom_range(1, SETTLE - 4)) @(negedge clk);
            cmdSel = 3'd0;
            repeat (SETTLE + 8) @(negedge clk);
        end
        repeat (IDLE_GAP) @(negedge clk);
        compareTraffic(doneBase);               // No lines expected
        if (busy !== 1'b0) begin
            $display("busy high after glitches");
            errCount++;
        end
        clearTraffic();
        finishTest("short glitches ignored", base);

        // Settled changes while a line is on the wire where only LEFT follows
        base     = errCount;
        doneBase = doneCount;
        cmdSel   = 3'(driveCmdPkg::FWD_MED);
        expMsgs.push_back(expectedText(driveCmdPkg::FWD_MED));
        while (busy !== 1'b1) @(negedge clk);
        holdCode(driveCmdPkg::REVERSE);
        holdCode(driveCmdPkg::FWD_SLOW);
        holdCode(driveCmdPkg::LEFT);
        if (doneCount != doneBase) begin
            $display("First line ended before the code changes were made");
            errCount++;
        end
        expMsgs.push_back(expectedText(driveCmdPkg::LEFT));
        waitForIdle(doneBase + 2);
        compareTraffic(doneBase);
        clearTraffic();
        finishTest("changes during a line", base);

        // Line returns to idle once msgDone is seen
        base     = errCount;
        doneBase = doneCount;
        badIdle  = 0;
        cmdSel   = 3'(driveCmdPkg::FWD_FAST);
        expMsgs.push_back(expectedText(driveCmdPkg::FWD_FAST));
        while (doneCount == doneBase) @(negedge clk);
        repeat (IDLE_GAP) begin
            if (txd !== 1'b1 || busy !== 1'b0) begin
                badIdle++;
            end
            @(negedge clk);
        end
        if (badIdle != 0) begin
            $display("Line not idle after msgDone in %0d cycles", badIdle);
            errCount++;
        end
        compareTraffic(doneBase);
        clearTraffic();
        finishTest("idle after msgDone", base);

        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/byteLink.sv */
`default_nettype none

// Byte stream from composer to UART queue, credit flow control
interface byteLink;

    driveCmdPkg::msgByte data;  // Character being sent
    logic                valid; // One byte per high cycle
    logic                last;  // Marks the newline
    logic                credit; // One-cycle pulse, one queue slot freed

    modport framer (
        output data,
        output valid,
        output last,
        input  credit
    );

    modport sender (
        input  data,
        input  valid,
        input  last,
        output credit
    );

endinterface

`default_nettype wire

/* verilog/cmdSelect.sv */
`default_nettype none

module cmdSelect #(
    parameter int SETTLE_CYCLES = 1000          // Stable cycles before accept
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           cmdSel,        // Raw switches, async
    input  logic                 cmdTake,       // Framer has taken the request
    output logic                 cmdValid,      // Request pending
    output driveCmdPkg::driveCmd cmd            // Latest accepted code
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [2:0]       syncQ1;                   // First sync stage
    logic [2:0]       syncQ2;                   // Second sync stage
    logic [2:0]       sampleQ;                  // Previous synced value
    logic [CNT_W-1:0] stableCnt;                // Cycles without change
    logic             haveCode;                 // Something accepted since reset
    logic             settled;
    logic             accept;

    // Stable long enough, fires once per run of equal samples
    assign settled = (syncQ2 == sampleQ) && (stableCnt == CNT_W'(SETTLE_CYCLES - 1));
    assign accept  = settled && (!haveCode || (syncQ2 != cmd));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncQ1  <= '0;
            syncQ2  <= '0;
            sampleQ <= '0;
        end else begin
            syncQ1  <= cmdSel;                  // Metastability guard
            syncQ2  <= syncQ1;
            sampleQ <= syncQ2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stableCnt <= '0;
        end else if (syncQ2 != sampleQ) begin
            stableCnt <= '0;                    // Glitch or new code, start over
        end else if (stableCnt != CNT_W'(SETTLE_CYCLES)) begin
            stableCnt <= stableCnt + CNT_W'(1); // Saturates so accept fires once
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            haveCode <= 1'b0;
            cmdValid <= 1'b0;
            cmd      <= driveCmdPkg::STOP;
        end else if (accept) begin
            haveCode <= 1'b1;
            cmdValid <= 1'b1;                   // New code wins over a pending one
            cmd      <= driveCmdPkg::driveCmd'(syncQ2);
        end else if (cmdTake) begin
            cmdValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/driveCmdPkg.sv */
`default_nettype none

package driveCmdPkg;

    localparam int BYTE_W = 8;              // Character width

    typedef logic [BYTE_W-1:0] msgByte;     // One ASCII character
    typedef logic [4:0]        msgLen;      // Message length, 28 at most

    // Switch codes as they come off the board
    typedef enum logic [2:0] {
        STOP     = 3'd0,                    // Both wheels halted
        LEFT     = 3'd1,                    // Spin left
        RIGHT    = 3'd2,                    // Spin right
        FWD_SLOW = 3'd3,
        FWD_MED  = 3'd4,
        FWD_FAST = 3'd5,
        REVERSE  = 3'd6,
        STOP_ALT = 3'd7                     // Spare code, also halts
    } driveCmd;

    // Message composer walks these segments in order
    typedef enum logic [2:0] {
        FR_IDLE,                            // Waiting for a request
        FR_PREFIX,                          // {"T":1,"L":
        FR_LEFTVAL,                         // Left wheel speed text
        FR_MIDDLE,                          // ,"R":
        FR_RIGHTVAL,                        // Right wheel speed text
        FR_SUFFIX                           // Closing brace and newline
    } framerState;

    // Serializer frame phases
    typedef enum logic [1:0] {
        TX_IDLE,                            // Line high, queue polled
        TX_START,                           // Start bit, low
        TX_DATA,                            // Eight data bits LSB first
        TX_STOP                             // Stop bit, high
    } txState;

endpackage

`default_nettype wire

/* verilog/jsonFramer.sv */
`default_nettype none

module jsonFramer #(
    parameter int FIFO_DEPTH = 4                // Initial credit count
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmdValid,
    input  driveCmdPkg::driveCmd cmd,
    output logic                 cmdTake,       // One cycle, only in idle
    byteLink.framer              link
);

    localparam int BW         = driveCmdPkg::BYTE_W;
    localparam int CRED_W     = $clog2(FIFO_DEPTH + 1);
    localparam int PREFIX_LEN = 11;
    localparam int MIDDLE_LEN = 5;
    localparam int SUFFIX_LEN = 2;
    localparam int VAL_MAX    = 5;              // Longest speed text, -0.25

    // Literals are right-aligned, first character on top
    localparam logic [PREFIX_LEN*BW-1:0] PREFIX_TXT = "{\"T\":1,\"L\":";
    localparam logic [MIDDLE_LEN*BW-1:0] MIDDLE_TXT = ",\"R\":";
    localparam logic [SUFFIX_LEN*BW-1:0] SUFFIX_TXT = "}\n";

    driveCmdPkg::framerState state;
    logic [3:0]              idx;               // Position inside segment
    logic [3:0]              segLen;
    logic                    segLast;
    logic [2:0]              leftSpd;           // Speed text index per wheel
    logic [2:0]              rightSpd;
    logic [VAL_MAX*BW-1:0]   valTxt;
    logic [CRED_W-1:0]       creditCnt;
    logic                    send;

    // Wheel speed per command, see speedText for codes
    function automatic logic [2:0] wheelSpeed(input driveCmdPkg::driveCmd c,
                                              input logic rightSide);
        case (c)
            driveCmdPkg::LEFT:     wheelSpeed = rightSide ? 3'd2 : 3'd1;
            driveCmdPkg::RIGHT:    wheelSpeed = rightSide ? 3'd1 : 3'd2;
            driveCmdPkg::FWD_SLOW: wheelSpeed = 3'd3;
            driveCmdPkg::FWD_MED:  wheelSpeed = 3'd4;
            driveCmdPkg::FWD_FAST: wheelSpeed = 3'd5;
            driveCmdPkg::REVERSE:  wheelSpeed = 3'd6;
            default:               wheelSpeed = 3'd0; // STOP and STOP_ALT
        endcase
    endfunction

    function automatic logic [VAL_MAX*BW-1:0] speedText(input logic [2:0] s);
        case (s)
            3'd1:    speedText = "-0.00";
            3'd2:    speedText = "0.12";
            3'd3:    speedText = "0.05";
            3'd4:    speedText = "0.25";
            3'd5:    speedText = "0.5";
            3'd6:    speedText = "-0.25";
            default: speedText = "0";
        endcase
    endfunction

    function automatic logic [3:0] speedLen(input logic [2:0] s);
        case (s)
            3'd1, 3'd6: speedLen = 4'd5;        // Signed values
            3'd5:       speedLen = 4'd3;
            3'd0, 3'd7: speedLen = 4'd1;        // Plain zero
            default:    speedLen = 4'd4;
        endcase
    endfunction

    assign cmdTake   = (state == driveCmdPkg::FR_IDLE) && cmdValid;
    assign send      = (state != driveCmdPkg::FR_IDLE) && (creditCnt != '0);
    assign segLast   = (idx == segLen - 4'd1);
    assign link.valid = send;
    assign link.last  = (state == driveCmdPkg::FR_SUFFIX) && segLast; // Newline

    // Segment length and current character
    always_comb begin
        segLen    = 4'd1;
        valTxt    = '0;
        link.data = '0;
        case (state)
            driveCmdPkg::FR_PREFIX: begin
                segLen    = 4'(PREFIX_LEN);
                link.data = PREFIX_TXT[(PREFIX_LEN - 1 - idx) * BW +: BW];
            end
            driveCmdPkg::FR_LEFTVAL: begin
                segLen    = speedLen(leftSpd);
                valTxt    = speedText(leftSpd);
                link.data = valTxt[(segLen - 4'd1 - idx) * BW +: BW];
            end
            driveCmdPkg::FR_MIDDLE: begin
                segLen    = 4'(MIDDLE_LEN);
                link.data = MIDDLE_TXT[(MIDDLE_LEN - 1 - idx) * BW +: BW];
            end
            driveCmdPkg::FR_RIGHTVAL: begin
                segLen    = speedLen(rightSpd);
                valTxt    = speedText(rightSpd);
                link.data = valTxt[(segLen - 4'd1 - idx) * BW +: BW];
            end
            driveCmdPkg::FR_SUFFIX: begin
                segLen    = 4'(SUFFIX_LEN);
                link.data = SUFFIX_TXT[(SUFFIX_LEN - 1 - idx) * BW +: BW];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmdTake) begin
            leftSpd  <= wheelSpeed(cmd, 1'b0);  // Held for whole message
            rightSpd <= wheelSpeed(cmd, 1'b1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= driveCmdPkg::FR_IDLE;
            idx   <= '0;
        end else if (cmdTake) begin
            state <= driveCmdPkg::FR_PREFIX;
            idx   <= '0;
        end else if (send) begin
            if (segLast) begin
                idx <= '0;
                case (state)
                    driveCmdPkg::FR_PREFIX:   state <= driveCmdPkg::FR_LEFTVAL;
                    driveCmdPkg::FR_LEFTVAL:  state <= driveCmdPkg::FR_MIDDLE;
                    driveCmdPkg::FR_MIDDLE:   state <= driveCmdPkg::FR_RIGHTVAL;
                    driveCmdPkg::FR_RIGHTVAL: state <= driveCmdPkg::FR_SUFFIX;
                    default:                  state <= driveCmdPkg::FR_IDLE;
                endcase
            end else begin
                idx <= idx + 4'd1;
            end
        end
    end

    // Slots free in the UART queue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            creditCnt <= CRED_W'(FIFO_DEPTH);
        end else begin
            case ({send, link.credit})
                2'b10:   creditCnt <= creditCnt - CRED_W'(1);
                2'b01:   creditCnt <= creditCnt + CRED_W'(1);
                default: ;                      // Both or neither, no change
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/motorLinkTop.sv */
`default_nettype none

module motorLinkTop #(
    parameter int CLKS_PER_BIT  = 434,          // Clocks per UART bit
    parameter int FIFO_DEPTH    = 4,            // Queue slots and credits
    parameter int SETTLE_CYCLES = 1000          // Switch debounce time
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] cmdSel,                  // Drive selection switches
    output logic       txd,                     // To robot UART RX
    output logic       busy,
    output logic       msgDone
);

    logic                 cmdValid;
    logic                 cmdTake;
    driveCmdPkg::driveCmd cmd;

    byteLink link ();                           // Composer to UART queue

    cmdSelect #(
        .SETTLE_CYCLES(SETTLE_CYCLES)
    ) uCmdSelect (
        .clk      (clk),
        .rst      (rst),
        .cmdSel   (cmdSel),
        .cmdTake  (cmdTake),
        .cmdValid (cmdValid),
        .cmd      (cmd)
    );

    jsonFramer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uJsonFramer (
        .clk      (clk),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .cmdTake  (cmdTake),
        .link     (link.framer)
    );

    uartSender #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) uUartSender (
        .clk     (clk),
        .rst     (rst),
        .link    (link.sender),
        .txd     (txd),
        .busy    (busy),
        .msgDone (msgDone)
    );

endmodule

`default_nettype wire

/* verilog/uartSender.sv */
`default_nettype none

module uartSender #(
    parameter int CLKS_PER_BIT = 434,           // 115200 baud at 50 MHz
    parameter int FIFO_DEPTH   = 4
) (
    input  logic     clk,
    input  logic     rst,
    byteLink.sender  link,
    output logic     txd,                       // 8N1 line, idles high
    output logic     busy,
    output logic     msgDone                    // Stop bit of newline done
);

    localparam int BW     = driveCmdPkg::BYTE_W;
    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [BW:0]         queueMem [FIFO_DEPTH]; // Last flag above the byte
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;
    logic [CNT_W-1:0]    fill;                  // Entries in queue
    logic                push;
    logic                pop;
    driveCmdPkg::txState state;
    logic [BAUD_W-1:0]   baudCnt;
    logic                baudDone;
    logic [2:0]          bitIdx;
    driveCmdPkg::msgByte shiftReg;
    logic                lastQ;                 // Byte in shifter ends message

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign push        = link.valid;            // Credits keep this from overflowing
    assign pop         = (state == driveCmdPkg::TX_IDLE) && (fill != '0);
    assign link.credit = pop;                   // Slot freed as byte enters shifter
    assign baudDone    = (baudCnt == BAUD_W'(CLKS_PER_BIT - 1));
    assign busy        = (fill != '0) || (state != driveCmdPkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (push) begin
            queueMem[wrPtr] <= {link.last, link.data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + CNT_W'(1);
                2'b01:   fill <= fill - CNT_W'(1);
                default: ;
            endcase
        end
    end

    // Shifter loads on pop, moves right after each data bit
    always_ff @(posedge clk) begin
        if (pop) begin
            {lastQ, shiftReg} <= queueMem[rdPtr];
        end else if ((state == driveCmdPkg::TX_DATA) && baudDone) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= driveCmdPkg::TX_IDLE;
            baudCnt <= '0;
            bitIdx  <= '0;
            txd     <= 1'b1;                    // Idle mark
            msgDone <= 1'b0;
        end else begin
            msgDone <= 1'b0;
            if (state != driveCmdPkg::TX_IDLE) begin
                baudCnt <= baudDone ? '0 : baudCnt + BAUD_W'(1);
            end
            case (state)
                driveCmdPkg::TX_IDLE: begin
                    txd <= 1'b1;
                    if (pop) begin
                        state   <= driveCmdPkg::TX_START;
                        baudCnt <= '0;
                        txd     <= 1'b0;        // Start bit
                    end
                end
                driveCmdPkg::TX_START: begin
                    if (baudDone) begin
                        state  <= driveCmdPkg::TX_DATA;
                        bitIdx <= '0;
                        txd    <= shiftReg[0];  // LSB first
                    end
                end
                driveCmdPkg::TX_DATA: begin
                    if (baudDone) begin
                        if (bitIdx == 3'(BW - 1)) begin
                            state <= driveCmdPkg::TX_STOP;
                            txd   <= 1'b1;      // Stop bit
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                            txd    <= shiftReg[1]; // Next bit before shift lands
                        end
                    end
                end
                driveCmdPkg::TX_STOP: begin
                    if (baudDone) begin
                        state   <= driveCmdPkg::TX_IDLE;
                        msgDone <= lastQ;
                    end
                end
                default: state <= driveCmdPkg::TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
